/* sources.f */
rtl/ApproxBranchTypes.sv
rtl/ApproxControlRegs.sv
rtl/DirectionPredictor.sv
rtl/LoopRegionTracker.sv
rtl/BranchDecider.sv
rtl/ApproxBranchUnit.sv
verification/ApproxBranchUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the ApproxBranchUnit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir

verilator --binary --timing --assert \
    --top-module ApproxBranchUnitTb \
    -Mdir "$buildDir" \
    -f sources.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

"./$buildDir/VApproxBranchUnitTb"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0

/* verification/ApproxBranchUnitTb.sv */
//**************************************************************************
// Approximate branch unit testbench
// Table-driven register, predictor, loop-timing and forced-exit checks
// against a reference model of counters, tracker and cycle count
//**************************************************************************
`default_nettype none

module ApproxBranchUnitTb import ApproxBranchTypes::*; ();

    localparam int ResetCycles = 10;
    localparam int StepCycleBudget = 20;
    localparam int HandshakeLimit = 8;

    typedef enum logic [2:0] {
        OpWrite,
        OpRead,
        OpResolve,
        OpQuery,
        OpIdle
    } StepOp;

    typedef struct packed {
        StepOp op;
        Pc pc;
        logic approx;
        logic taken;
        RegAddr addr;
        RegData data;
    } Step;

    logic clk;
    logic reset;
    logic regReq;
    logic regWrite;
    RegAddr regAddr;
    RegData regWriteData;
    logic regAck;
    RegData regReadData;
    logic queryValid;
    Pc queryPc;
    logic queryApprox;
    logic resolveValid;
    Pc resolvePc;
    logic resolveTaken;
    logic resolveApprox;
    logic decisionValid;
    logic decisionTaken;
    logic approxExit;

    Step steps[$];
    int cycleLimit;
    int elapsedCycles = 0;

    // Reference model state
    logic [1:0] modelCounter [PredEntries];
    logic trackValid [TrackerEntries];
    Pc trackTag [TrackerEntries];
    Cycle trackBegin [TrackerEntries];
    Cycle modelCycle;
    AxLevel modelLevel;
    Threshold modelThreshold;
    RegData lastCycleRead;
    logic haveCycleRead;

    ApproxBranchUnit i_dut (
        .clk(clk),
        .reset(reset),
        .regReq(regReq),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWriteData(regWriteData),
        .regAck(regAck),
        .regReadData(regReadData),
        .queryValid(queryValid),
        .queryPc(queryPc),
        .queryApprox(queryApprox),
        .resolveValid(resolveValid),
        .resolvePc(resolvePc),
        .resolveTaken(resolveTaken),
        .resolveApprox(resolveApprox),
        .decisionValid(decisionValid),
        .decisionTaken(decisionTaken),
        .approxExit(approxExit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Model cycle count, 0 in the first cycle after reset
    always @(posedge clk) begin
        if (reset) begin
            modelCycle <= '0;
        end else begin
            modelCycle <= modelCycle + 32'd1;
        end
    end

    always @(posedge clk) begin
        elapsedCycles <= elapsedCycles + 1;
        if (elapsedCycles > cycleLimit) begin
            stopRun("Simulation ran past its cycle limit without finishing the table");
        end
    end

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else begin
            stopRun($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h",
                name, got, expected));
        end
    endtask

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic appendStep(input StepOp op, input Pc pc, input logic approx,
                              input logic taken, input RegAddr addr, input RegData data);
        Step s;
        s.op = op;
        s.pc = pc;
        s.approx = approx;
        s.taken = taken;
        s.addr = addr;
        s.data = data;
        steps.push_back(s);
    endtask

    task automatic buildTable();
        logic [31:0] seed;
        Pc pc;
        seed = 32'h5bd1;
        // Query straight out of reset
        appendStep(OpQuery, 32'h100, 1'b0, 1'b0, 2'd0, 32'd0);
        appendStep(OpWrite, 32'h0, 1'b0, 1'b0, AddrAxLevel, 32'd2);
        appendStep(OpWrite, 32'h0, 1'b0, 1'b0, AddrThreshold, 32'h1234);
        appendStep(OpRead, 32'h0, 1'b0, 1'b0, AddrAxLevel, 32'd2);
        appendStep(OpRead, 32'h0, 1'b0, 1'b0, AddrThreshold, 32'h1234);
        appendStep(OpRead, 32'h0, 1'b0, 1'b0, AddrCycle, 32'd0);
        appendStep(OpIdle, 32'h0, 1'b0, 1'b0, 2'd0, 32'd3);
        appendStep(OpRead, 32'h0, 1'b0, 1'b0, AddrCycle, 32'd0);
        appendStep(OpWrite, 32'h0, 1'b0, 1'b0, AddrCycle, 32'd0);
        appendStep(OpRead, 32'h0, 1'b0, 1'b0, AddrCycle, 32'd0);
        // Drive one counter into both saturation points
        for (int i = 0; i < 8; i++) begin
            appendStep(OpResolve, 32'h150, 1'b0, (i < 4), 2'd0, 32'd0);
            appendStep(OpQuery, 32'h150, 1'b0, 1'b0, 2'd0, 32'd0);
        end
        for (int i = 0; i < 24; i++) begin
            seed = nextRandom(seed);
            pc = 32'h200 | Pc'({seed[18:17], 2'b00});
            appendStep(OpResolve, pc, 1'b0, seed[16], 2'd0, 32'd0);
            appendStep(OpQuery, pc, 1'b0, 1'b0, 2'd0, 32'd0);
        end
        // Level 0 keeps approximation off
        appendStep(OpWrite, 32'h0, 1'b0, 1'b0, AddrAxLevel, 32'd0);
        appendStep(OpWrite, 32'h0, 1'b0, 1'b0, AddrThreshold, 32'd4);
        appendStep(OpResolve, 32'h1018, 1'b0, 1'b1, 2'd0, 32'd0);
        appendStep(OpResolve, 32'h1018, 1'b0, 1'b1, 2'd0, 32'd0);
        for (int i = 0; i < 12; i++) begin
            appendStep(OpQuery, 32'h1018, 1'b1, 1'b0, 2'd0, 32'd0);
        end
        appendStep(OpWrite, 32'h0, 1'b0, 1'b0, AddrThreshold, 32'd16);
        for (int lvl = 1; lvl <= 3; lvl++) begin
            appendStep(OpWrite, 32'h0, 1'b0, 1'b0, AddrAxLevel, RegData'(lvl));
            appendStep(OpResolve, 32'h2024, 1'b0, 1'b1, 2'd0, 32'd0);
            appendStep(OpResolve, 32'h2024, 1'b0, 1'b1, 2'd0, 32'd0);
            for (int n = 0; n < (16 >> (lvl - 1)) + 3; n++) begin
                appendStep(OpQuery, 32'h2024, 1'b1, 1'b0, 2'd0, 32'd0);
            end
            // Loop exit clears the region
            appendStep(OpResolve, 32'h2024, 1'b1, 1'b0, 2'd0, 32'd0);
        end
        for (int n = 0; n < 7; n++) begin
            appendStep(OpQuery, 32'h2024, 1'b1, 1'b0, 2'd0, 32'd0);
        end
    endtask

    task automatic registerAccess(input logic write, input RegAddr addr, input RegData data,
                                  output RegData readData, output Cycle accessCycle);
        int waited;
        accessCycle = modelCycle;
        regReq = 1'b1;
        regWrite = write;
        regAddr = addr;
        regWriteData = data;
        waited = 0;
        while (regAck !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > HandshakeLimit) begin
                stopRun("regAck did not rise while regReq was held high");
            end
        end
        readData = regReadData;
        regReq = 1'b0;
        waited = 0;
        while (regAck !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > HandshakeLimit) begin
                stopRun("regAck stayed high after regReq was dropped");
            end
        end
    endtask

    task automatic applyStep(input Step s);
        logic [3:0] pIdx;
        logic [1:0] tIdx;
        logic pred;
        logic hit;
        logic expExit;
        logic expTaken;
        Cycle limit;
        RegData readData;
        Cycle accessCycle;
        pIdx = s.pc[5:2];
        tIdx = s.pc[3:2];
        case (s.op)
            OpWrite: begin
                registerAccess(1'b1, s.addr, s.data, readData, accessCycle);
                if (s.addr == AddrAxLevel) begin
                    modelLevel = s.data[AxLevelWidth-1:0];
                end else if (s.addr == AddrThreshold) begin
                    modelThreshold = s.data[ThresholdWidth-1:0];
                end
            end
            OpRead: begin
                registerAccess(1'b0, s.addr, 32'd0, readData, accessCycle);
                if (s.addr == AddrCycle) begin
                    checkValue("regReadData", readData, accessCycle);
                    if (haveCycleRead) begin
                        assert (readData > lastCycleRead) else begin
                            stopRun($sformatf("CHECK FAILED regReadData 0x%08h not above 0x%08h",
                                readData, lastCycleRead));
                        end
                    end
                    lastCycleRead = readData;
                    haveCycleRead = 1'b1;
                end else begin
                    checkValue("regReadData", readData, s.data);
                end
            end
            OpResolve: begin
                if (s.taken && modelCounter[pIdx] != 2'd3) begin
                    modelCounter[pIdx] = modelCounter[pIdx] + 2'd1;
                end else if (!s.taken && modelCounter[pIdx] != 2'd0) begin
                    modelCounter[pIdx] = modelCounter[pIdx] - 2'd1;
                end
                if (s.approx && !s.taken && trackValid[tIdx] && trackTag[tIdx] == s.pc) begin
                    trackValid[tIdx] = 1'b0;
                end
                resolveValid = 1'b1;
                resolvePc = s.pc;
                resolveTaken = s.taken;
                resolveApprox = s.approx;
                @(negedge clk);
                resolveValid = 1'b0;
            end
            OpQuery: begin
                pred = modelCounter[pIdx][1];
                hit = trackValid[tIdx] && (trackTag[tIdx] == s.pc);
                expExit = 1'b0;
                if (modelLevel != 2'd0 && s.approx && hit) begin
                    limit = 32'(modelThreshold) >> (modelLevel - 2'd1);
                    expExit = (modelCycle - trackBegin[tIdx]) >= limit;
                end
                expTaken = expExit ? 1'b0 : pred;
                if (s.approx && !hit) begin
                    trackValid[tIdx] = 1'b1;
                    trackTag[tIdx] = s.pc;
                    trackBegin[tIdx] = modelCycle;
                end
                queryValid = 1'b1;
                queryPc = s.pc;
                queryApprox = s.approx;
                @(negedge clk);
                queryValid = 1'b0;
                checkValue("decisionValid", 32'(decisionValid), 32'd1);
                checkValue("decisionTaken", 32'(decisionTaken), 32'(expTaken));
                checkValue("approxExit", 32'(approxExit), 32'(expExit));
            end
            default: begin
                repeat (s.data) @(negedge clk);
            end
        endcase
    endtask

    initial begin
        buildTable();
        cycleLimit = steps.size() * StepCycleBudget + ResetCycles;
        reset = 1'b1;
        regReq = 1'b0;
        regWrite = 1'b0;
        regAddr = '0;
        regWriteData = '0;
        queryValid = 1'b0;
        queryPc = '0;
        queryApprox = 1'b0;
        resolveValid = 1'b0;
        resolvePc = '0;
        resolveTaken = 1'b0;
        resolveApprox = 1'b0;
        for (int i = 0; i < PredEntries; i++) begin
            modelCounter[i] = 2'd1;
        end
        for (int i = 0; i < TrackerEntries; i++) begin
            trackValid[i] = 1'b0;
            trackTag[i] = '0;
            trackBegin[i] = '0;
        end
        modelLevel = '0;
        modelThreshold = '0;
        lastCycleRead = '0;
        haveCycleRead = 1'b0;
        repeat (ResetCycles) @(negedge clk);
        reset = 1'b0;
        checkValue("regAck", 32'(regAck), 32'd0);
        checkValue("decisionValid", 32'(decisionValid), 32'd0);
        checkValue("approxExit", 32'(approxExit), 32'd0);
        for (int i = 0; i < steps.size(); i++) begin
            applyStep(steps[i]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/ApproxBranchUnit.sv */
//**************************************************************************
// Approximate branch unit
// Joins control registers, direction predictor, loop tracker and decider
//**************************************************************************
`default_nettype none

module ApproxBranchUnit import ApproxBranchTypes::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   regReq,
    input  wire logic   regWrite,
    input  wire RegAddr regAddr,
    input  wire RegData regWriteData,
    output logic        regAck,
    output RegData      regReadData,
    input  wire logic   queryValid,
    input  wire Pc      queryPc,
    input  wire logic   queryApprox,
    input  wire logic   resolveValid,
    input  wire Pc      resolvePc,
    input  wire logic   resolveTaken,
    input  wire logic   resolveApprox,
    output logic        decisionValid,
    output logic        decisionTaken,
    output logic        approxExit
);

    AxLevel axLevel;
    Threshold axThreshold;
    Cycle cycleCount;
    logic predTaken;
    logic trackHit;
    Cycle beginCycle;

    ApproxControlRegs i_controlRegs (
        .clk(clk),
        .reset(reset),
        .regReq(regReq),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWriteData(regWriteData),
        .regAck(regAck),
        .regReadData(regReadData),
        .axLevel(axLevel),
        .axThreshold(axThreshold),
        .cycleCount(cycleCount)
    );

    DirectionPredictor i_predictor (
        .clk(clk),
        .reset(reset),
        .queryPc(queryPc),
        .resolveValid(resolveValid),
        .resolvePc(resolvePc),
        .resolveTaken(resolveTaken),
        .predTaken(predTaken)
    );

    LoopRegionTracker i_tracker (
        .clk(clk),
        .reset(reset),
        .queryValid(queryValid),
        .queryPc(queryPc),
        .queryApprox(queryApprox),
        .resolveValid(resolveValid),
        .resolvePc(resolvePc),
        .resolveTaken(resolveTaken),
        .resolveApprox(resolveApprox),
        .cycleCount(cycleCount),
        .trackHit(trackHit),
        .beginCycle(beginCycle)
    );

    BranchDecider i_decider (
        .clk(clk),
        .reset(reset),
        .queryValid(queryValid),
        .queryApprox(queryApprox),
        .predTaken(predTaken),
        .trackHit(trackHit),
        .beginCycle(beginCycle),
        .cycleCount(cycleCount),
        .axLevel(axLevel),
        .axThreshold(axThreshold),
        .decisionValid(decisionValid),
        .decisionTaken(decisionTaken),
        .approxExit(approxExit)
    );

endmodule

`default_nettype wire

/* rtl/BranchDecider.sv */
//**************************************************************************
// Branch decider
// Forces a not-taken approximate exit once a tracked loop has run past the
// level-scaled threshold, otherwise passes the predicted direction
//**************************************************************************
`default_nettype none

module BranchDecider import ApproxBranchTypes::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     queryValid,
    input  wire logic     queryApprox,
    input  wire logic     predTaken,
    input  wire logic     trackHit,
    input  wire Cycle     beginCycle,
    input  wire Cycle     cycleCount,
    input  wire AxLevel   axLevel,
    input  wire Threshold axThreshold,
    output logic          decisionValid,
    output logic          decisionTaken,
    output logic          approxExit
);

    AxLevel limitShift;
    Cycle effectiveLimit;
    Cycle elapsed;
    logic axEnabled;
    logic exitNow;

    // Level 1 full threshold, 2 half, 3 quarter
    assign limitShift = axLevel - AxLevel'(1);
    assign effectiveLimit = Cycle'(axThreshold) >> limitShift;

    assign elapsed = cycleCount - beginCycle;
    assign axEnabled = (axLevel != '0);

    assign exitNow = queryValid && axEnabled && queryApprox && trackHit
        && (elapsed >= effectiveLimit);

    always_ff @(posedge clk) begin
        if (reset) begin
            decisionValid <= 1'b0;
            decisionTaken <= 1'b0;
            approxExit <= 1'b0;
        end else begin
            decisionValid <= queryValid;
            decisionTaken <= queryValid && predTaken && !exitNow;
            approxExit <= exitNow;
        end
    end

endmodule

`default_nettype wire

/* rtl/LoopRegionTracker.sv */
//**************************************************************************
// Loop region tracker
// Records the cycle an approximable loop branch was first seen, so the
// decider can time how long the loop has been running
//**************************************************************************
`default_nettype none

module LoopRegionTracker import ApproxBranchTypes::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic queryValid,
    input  wire Pc    queryPc,
    input  wire logic queryApprox,
    input  wire logic resolveValid,
    input  wire Pc    resolvePc,
    input  wire logic resolveTaken,
    input  wire logic resolveApprox,
    input  wire Cycle cycleCount,
    output logic      trackHit,
    output Cycle      beginCycle
);

    logic entryValid [TrackerEntries];
    Pc entryTag [TrackerEntries];
    Cycle entryBegin [TrackerEntries];

    TrackerIndex queryIdx;
    TrackerIndex resolveIdx;
    logic resolveHit;
    logic allocate;
    logic exitClear;

    assign queryIdx = queryPc[TrackerIndexBits+1:2];
    assign resolveIdx = resolvePc[TrackerIndexBits+1:2];

    assign trackHit = entryValid[queryIdx] && (entryTag[queryIdx] == queryPc);
    assign beginCycle = entryBegin[queryIdx];

    assign resolveHit = entryValid[resolveIdx] && (entryTag[resolveIdx] == resolvePc);

    // New loop run starts timing on its first approximable query
    assign allocate = queryValid && queryApprox && !trackHit;

    // Not-taken loop branch means the loop exited
    assign exitClear = resolveValid && resolveApprox && !resolveTaken && resolveHit;

    // Allocation overrides a clear of the same slot
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TrackerEntries; i++) begin
                entryValid[i] <= 1'b0;
            end
        end else begin
            if (exitClear) begin
                entryValid[resolveIdx] <= 1'b0;
            end
            if (allocate) begin
                entryValid[queryIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocate) begin
            entryTag[queryIdx] <= queryPc;
            entryBegin[queryIdx] <= cycleCount;
        end
    end

endmodule

`default_nettype wire

/* rtl/DirectionPredictor.sv */
//**************************************************************************
// Direction predictor
// Sixteen two-bit saturating counters, read on query, trained on resolve
//**************************************************************************
`default_nettype none

module DirectionPredictor import ApproxBranchTypes::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire Pc    queryPc,
    input  wire logic resolveValid,
    input  wire Pc    resolvePc,
    input  wire logic resolveTaken,
    output logic      predTaken
);

    PredCounter counters [PredEntries];
    PredIndex queryIdx;
    PredIndex resolveIdx;
    PredCounter resolveCounter;
    PredCounter trainedCounter;

    assign queryIdx = queryPc[PredIndexBits+1:2];
    assign resolveIdx = resolvePc[PredIndexBits+1:2];

    // Reads the pre-update table when query and resolve collide
    assign predTaken = counters[queryIdx][1];

    assign resolveCounter = counters[resolveIdx];

    always_comb begin
        trainedCounter = resolveCounter;
        if (resolveTaken) begin
            if (resolveCounter != '1) begin
                trainedCounter = resolveCounter + PredCounter'(1);
            end
        end else begin
            if (resolveCounter != '0) begin
                trainedCounter = resolveCounter - PredCounter'(1);
            end
        end
    end

    // Weakly not-taken after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PredEntries; i++) begin
                counters[i] <= PredCounterInit;
            end
        end else if (resolveValid) begin
            counters[resolveIdx] <= trainedCounter;
        end
    end

endmodule

`default_nettype wire

/* rtl/ApproxControlRegs.sv */
//**************************************************************************
// Approximation control registers
// Level and threshold registers plus a free-running cycle counter,
// accessed over a four-phase req/ack register port
//**************************************************************************
`default_nettype none

module ApproxControlRegs import ApproxBranchTypes::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   regReq,
    input  wire logic   regWrite,
    input  wire RegAddr regAddr,
    input  wire RegData regWriteData,
    output logic        regAck,
    output RegData      regReadData,
    output AxLevel      axLevel,
    output Threshold    axThreshold,
    output Cycle        cycleCount
);

    RegPortState state;
    RegData readValue;
    logic accessNow;

    // Access happens once per request, on entry to the acked phase
    assign accessNow = (state == RegIdle) && regReq;
    assign regAck = (state == RegAcked);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RegIdle;
        end else begin
            case (state)
                RegIdle: begin
                    if (regReq) begin
                        state <= RegAcked;
                    end
                end
                RegAcked: begin
                    if (!regReq) begin
                        state <= RegIdle;
                    end
                end
                default: state <= RegIdle;
            endcase
        end
    end

    // Cycle counter is read-only, so only two registers take writes
    always_ff @(posedge clk) begin
        if (reset) begin
            axLevel <= '0;
            axThreshold <= '0;
        end else if (accessNow && regWrite) begin
            case (regAddr)
                AddrAxLevel: axLevel <= regWriteData[AxLevelWidth-1:0];
                AddrThreshold: axThreshold <= regWriteData[ThresholdWidth-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (regAddr)
            AddrAxLevel: readValue = RegData'(axLevel);
            AddrThreshold: readValue = RegData'(axThreshold);
            AddrCycle: readValue = RegData'(cycleCount);
            default: readValue = '0;
        endcase
    end

    // Holds the addressed value as of the access edge
    always_ff @(posedge clk) begin
        if (accessNow) begin
            regReadData <= readValue;
        end
    end

    // Stands in for the core's cycle CSR
    always_ff @(posedge clk) begin
        if (reset) begin
            cycleCount <= '0;
        end else begin
            cycleCount <= cycleCount + Cycle'(1);
        end
    end

endmodule

`default_nettype wire

/* rtl/ApproxBranchTypes.sv */
//**************************************************************************
// Approximate branch path types
// Widths, typedefs, register map and register-port state encoding shared
// by the approximate-computing branch subsystem
//**************************************************************************
`default_nettype none

package ApproxBranchTypes;

    localparam int PcWidth = 32;
    typedef logic [PcWidth-1:0] Pc;

    localparam int CycleWidth = 32;
    typedef logic [CycleWidth-1:0] Cycle;

    // Level 0 turns approximation off
    localparam int AxLevelWidth = 2;
    typedef logic [AxLevelWidth-1:0] AxLevel;

    localparam int ThresholdWidth = 16;
    typedef logic [ThresholdWidth-1:0] Threshold;

    localparam int RegAddrWidth = 2;
    typedef logic [RegAddrWidth-1:0] RegAddr;

    localparam int RegDataWidth = 32;
    typedef logic [RegDataWidth-1:0] RegData;

    // Predictor indexed by PC[5:2]
    localparam int PredIndexBits = 4;
    localparam int PredEntries = 1 << PredIndexBits;
    typedef logic [PredIndexBits-1:0] PredIndex;
    typedef logic [1:0] PredCounter;
    localparam PredCounter PredCounterInit = 2'd1;

    // Tracker indexed by PC[3:2], tagged with the full PC
    localparam int TrackerEntries = 4;
    localparam int TrackerIndexBits = 2;
    typedef logic [TrackerIndexBits-1:0] TrackerIndex;

    localparam RegAddr AddrAxLevel = 2'd0;
    localparam RegAddr AddrThreshold = 2'd1;
    localparam RegAddr AddrCycle = 2'd2;

    typedef enum logic {
        RegIdle,
        RegAcked
    } RegPortState;

endpackage

`default_nettype wire
